/* common/adc_pkg.sv */
`default_nettype none

package adc_pkg;

	////////////////////////////////////////
	// device data format
	////////////////////////////////////////

	localparam int SAMPLE_W    = 18;             // bits per conversion result
	localparam int N_CHAN      = 8;              // channels on the device
	localparam int N_PAIR      = N_CHAN / 2;     // port a carries 0..3, port b 4..7
	localparam int CHAN_IDX_W  = 3;
	localparam int PAIR_W      = $clog2(N_PAIR);

	// serial read length per data line and frame
	localparam int RD_LENGTH   = SAMPLE_W * N_PAIR;
	localparam int RD_CYCLES   = 2 * RD_LENGTH;  // sclk at half rate

	////////////////////////////////////////
	// conversion timing and oversampling
	////////////////////////////////////////

	localparam int MIN_T_CYCLE = 85;             // 5 us at 17 MHz
	localparam int OS_W        = 3;
	localparam logic [OS_W-1:0] OS_MIN = OS_W'(1); // 8 channels need at least 2x

	// counter widths
	localparam int CV_CNT_W    = $clog2(MIN_T_CYCLE + 1);
	localparam int RD_CNT_W    = $clog2(RD_CYCLES);
	localparam int BIT_CNT_W   = $clog2(SAMPLE_W);

	// sequencer state codes
	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] CV_IDLE   = 2'd0;  // waiting for run
	localparam logic [ST_W-1:0] CV_CONVST = 2'd1;  // convst pulse
	localparam logic [ST_W-1:0] CV_WAIT   = 2'd2;  // cycle time and busy
	localparam logic [ST_W-1:0] RD_IDLE   = 2'd0;  // waiting for busy rise
	localparam logic [ST_W-1:0] RD_SHIFT  = 2'd1;  // cs low, clocking bits
	localparam logic [ST_W-1:0] RD_WAIT   = 2'd2;  // waiting for busy low

endpackage

`default_nettype wire

/* common/wb_regs_pkg.sv */
`default_nettype none

package wb_regs_pkg;

	////////////////////////////////////////
	// bus geometry
	////////////////////////////////////////

	localparam int WB_ADDR_W = 8;                // byte address
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W  = WB_DATA_W / 8;

	// register map
	localparam logic [WB_ADDR_W-1:0] ADDR_CTRL        = 8'h00;
	localparam logic [WB_ADDR_W-1:0] ADDR_STATUS      = 8'h04;
	localparam logic [WB_ADDR_W-1:0] ADDR_SAMPLE_BASE = 8'h20;  // 32 byte aligned
	localparam logic [WB_ADDR_W-1:0] ADDR_SAMPLE_LAST =
		ADDR_SAMPLE_BASE + WB_ADDR_W'(4 * (adc_pkg::N_CHAN - 1));

	// ctrl fields
	localparam int CTRL_RUN_BIT = 0;
	localparam int CTRL_OS_LSB  = 1;             // os code in bits 3:1

	localparam int FRAME_CNT_W  = 16;

	////////////////////////////////////////
	// readback word, two decodings
	////////////////////////////////////////

	localparam int SMP_CHAN_W  = 4;
	localparam int SMP_RSVD_W  = WB_DATA_W - SMP_CHAN_W - adc_pkg::SAMPLE_W;
	localparam int STAT_RSVD_W = WB_DATA_W - FRAME_CNT_W - 1 - adc_pkg::OS_W;

	typedef struct packed {
		logic [SMP_CHAN_W-1:0]               chan;   // channel index, top nibble
		logic [SMP_RSVD_W-1:0]               rsvd;
		logic signed [adc_pkg::SAMPLE_W-1:0] value;
	} sample_view_t;

	typedef struct packed {
		logic [FRAME_CNT_W-1:0]   frame_cnt;
		logic [STAT_RSVD_W-1:0]   rsvd;
		logic                     running;
		logic [adc_pkg::OS_W-1:0] os_code;       // active ratio
	} status_view_t;

	typedef union packed {
		sample_view_t sample_view;
		status_view_t status_view;
	} adc_word_u;

endpackage

`default_nettype wire

/* common/conv_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

// run and ratio settings down, converter state back up
interface conv_cfg_if ();
	import adc_pkg::*;

	logic            run;        // continuous conversion enable
	logic [OS_W-1:0] os_code;    // already clamped to OS_MIN
	logic            running;    // convert fsm out of idle
	logic            busy_seen;  // registered device busy

	modport dec (
		output run,
		output os_code,
		input  running,
		input  busy_seen
	);

	modport seq (
		input  run,
		input  os_code,
		output running,
		output busy_seen
	);

endinterface

`default_nettype wire

/* common/sample_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one channel pair per valid pulse, no ready
interface sample_if ();
	import adc_pkg::*;

	logic                       valid;      // single cycle
	logic [PAIR_W-1:0]          pair_idx;   // 0..3
	logic signed [SAMPLE_W-1:0] value_a;    // channel pair_idx
	logic signed [SAMPLE_W-1:0] value_b;    // channel pair_idx + 4
	logic                       frame_end;  // with the last pair

	modport seq (
		output valid,
		output pair_idx,
		output value_a,
		output value_b,
		output frame_end
	);

	modport store (
		input valid,
		input pair_idx,
		input value_a,
		input value_b,
		input frame_end
	);

endinterface

`default_nettype wire

/* hw/wb_reg_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_reg_decode (
	input  wire                                  clk_in,
	input  wire                                  reset_in,
	input  wire                                  wb_cyc,
	input  wire                                  wb_stb,
	input  wire                                  wb_we,
	input  wire  [wb_regs_pkg::WB_ADDR_W-1:0]    wb_adr,
	input  wire  [wb_regs_pkg::WB_DATA_W-1:0]    wb_dat_w,
	input  wire  [wb_regs_pkg::WB_SEL_W-1:0]     wb_sel,
	output logic [wb_regs_pkg::WB_DATA_W-1:0]    wb_dat_r,
	output logic                                 wb_ack,
	output logic [adc_pkg::CHAN_IDX_W-1:0]       rd_idx,    // to sample store
	input  wire signed [adc_pkg::SAMPLE_W-1:0]   rd_value,
	input  wire  [wb_regs_pkg::FRAME_CNT_W-1:0]  frame_cnt,
	conv_cfg_if.dec                              cfg
);
	import adc_pkg::*;
	import wb_regs_pkg::*;

	logic                 req;         // new request, not the ack cycle
	logic                 sel_ctrl;
	logic                 sel_status;
	logic                 sel_sample;
	logic [OS_W-1:0]      os_req;      // os field of the write data
	adc_word_u            rd_word;
	logic [WB_DATA_W-1:0] rd_data;

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////

	assign req        = wb_cyc && wb_stb && !wb_ack;
	assign sel_ctrl   = (wb_adr == ADDR_CTRL);
	assign sel_status = (wb_adr == ADDR_STATUS);
	assign sel_sample = (wb_adr >= ADDR_SAMPLE_BASE) && (wb_adr <= ADDR_SAMPLE_LAST) &&
		(wb_adr[1:0] == 2'b00);

	assign rd_idx = wb_adr[2 +: CHAN_IDX_W];  // base is 32 byte aligned
	assign os_req = wb_dat_w[CTRL_OS_LSB +: OS_W];

	// readback mux, unmapped stays zero
	always_comb begin
		rd_word = '0;
		rd_data = '0;
		if (sel_ctrl) begin
			rd_data[CTRL_RUN_BIT]          = cfg.run;
			rd_data[CTRL_OS_LSB +: OS_W]   = cfg.os_code;
		end else if (sel_status) begin
			rd_word.status_view.frame_cnt = frame_cnt;
			// a device conversion still finishing counts as running
			rd_word.status_view.running   = cfg.running || cfg.busy_seen;
			rd_word.status_view.os_code   = cfg.os_code;
			rd_data = rd_word;
		end else if (sel_sample) begin
			rd_word.sample_view.chan  = SMP_CHAN_W'(rd_idx);
			rd_word.sample_view.rsvd  = {SMP_RSVD_W{rd_value[SAMPLE_W-1]}};  // sign copies
			rd_word.sample_view.value = rd_value;
			rd_data = rd_word;
		end
	end

	////////////////////////////////////////
	// ctrl register and ack
	////////////////////////////////////////

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			wb_ack      <= 1'b0;
			wb_dat_r    <= '0;
			cfg.run     <= 1'b0;
			cfg.os_code <= OS_MIN;
		end else begin
			wb_ack <= req;  // one cycle after request
			if (req) begin
				wb_dat_r <= rd_data;  // held only while ack is high for the master
			end
			// read only and unmapped writes fall through
			if (req && wb_we && sel_ctrl && wb_sel[0]) begin
				cfg.run     <= wb_dat_w[CTRL_RUN_BIT];
				cfg.os_code <= (os_req < OS_MIN) ? OS_MIN : os_req;  // clamp
			end
		end
	end

endmodule

`default_nettype wire

/* adc_seq/adc_seq.sv */
`timescale 1ns/1ps
`default_nettype none

// continuous conversion, two independent fsms
// convert fsm paces convst, read fsm clocks the previous result out
module adc_seq (
	input  wire                        clk_in,
	input  wire                        reset_in,
	input  wire                        busy,       // device busy
	input  wire                        data_a,     // serial line, channels 0..3
	input  wire                        data_b,     // serial line, channels 4..7
	output logic [adc_pkg::OS_W-1:0]   os_pins,
	output logic                       convst,     // active low
	output logic                       sclk,
	output logic                       n_cs,
	output logic                       adc_reset,
	conv_cfg_if.seq                    cfg,
	sample_if.seq                      smp
);
	import adc_pkg::*;

	logic [ST_W-1:0]            cv_state;
	logic [ST_W-1:0]            cv_next;
	logic [CV_CNT_W-1:0]        cv_cnt;     // cycles since convst, saturating
	logic                       cv_done;
	logic [OS_W-1:0]            os_q;

	logic [ST_W-1:0]            rd_state;
	logic [ST_W-1:0]            rd_next;
	logic [RD_CNT_W-1:0]        rd_cnt;     // cycles with cs low
	logic [BIT_CNT_W-1:0]       bit_cnt;    // bit within the word
	logic [PAIR_W-1:0]          pair_cnt;
	logic                       busy_q;
	logic                       sclk_q;
	logic                       shift_en;   // sclk rises at this edge
	logic                       word_done;
	logic signed [SAMPLE_W-1:0] sh_a;
	logic signed [SAMPLE_W-1:0] sh_b;

	assign adc_reset     = reset_in;  // device reset tracks system reset
	assign os_pins       = os_q;
	assign cfg.busy_seen = busy_q;

	////////////////////////////////////////
	// convert fsm
	////////////////////////////////////////

	// next convst lands MIN_T_CYCLE after the last one at the earliest
	// and never while the read port is still shifting
	assign cv_done = (cv_cnt >= CV_CNT_W'(MIN_T_CYCLE - 1)) && !busy &&
		(rd_state != RD_SHIFT);

	always_comb begin
		cv_next = cv_state;
		case (cv_state)
			CV_IDLE:   if (cfg.run) cv_next = CV_CONVST;
			CV_CONVST: cv_next = CV_WAIT;  // one cycle pulse
			CV_WAIT:   if (cv_done) cv_next = cfg.run ? CV_CONVST : CV_IDLE;
			default:   cv_next = CV_IDLE;
		endcase
	end

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			cv_state <= CV_IDLE;
			cv_cnt   <= '0;
			os_q     <= OS_MIN;
			busy_q   <= 1'b0;
		end else begin
			cv_state <= cv_next;
			busy_q   <= busy;
			if (cv_state == CV_CONVST)
				cv_cnt <= CV_CNT_W'(1);
			else if (cv_cnt != '1)
				cv_cnt <= cv_cnt + 1'b1;
			// ratio only changes between runs
			if (cv_state == CV_IDLE)
				os_q <= cfg.os_code;
		end
	end

	assign convst      = (cv_state != CV_CONVST);
	assign cfg.running = (cv_state != CV_IDLE);

	////////////////////////////////////////
	// read fsm
	////////////////////////////////////////

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			RD_IDLE:  if (busy && !busy_q) rd_next = RD_SHIFT;  // busy rising
			RD_SHIFT: if (rd_cnt == RD_CNT_W'(RD_CYCLES - 1)) rd_next = RD_WAIT;
			RD_WAIT:  if (!busy) rd_next = RD_IDLE;
			default:  rd_next = RD_IDLE;
		endcase
	end

	assign shift_en  = (rd_state == RD_SHIFT) && !sclk_q;
	assign word_done = shift_en && (bit_cnt == BIT_CNT_W'(SAMPLE_W - 1));

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			rd_state      <= RD_IDLE;
			rd_cnt        <= '0;
			bit_cnt       <= '0;
			pair_cnt      <= '0;
			sclk_q        <= 1'b0;
			smp.valid     <= 1'b0;
			smp.frame_end <= 1'b0;
		end else begin
			rd_state <= rd_next;
			if (rd_state == RD_SHIFT) begin
				rd_cnt <= rd_cnt + 1'b1;
				sclk_q <= (rd_next == RD_SHIFT) ? !sclk_q : 1'b0;  // park low at cs rise
			end else begin
				rd_cnt   <= '0;
				sclk_q   <= 1'b0;
				bit_cnt  <= '0;
				pair_cnt <= '0;
			end
			if (shift_en) begin
				bit_cnt <= word_done ? '0 : bit_cnt + 1'b1;
				if (word_done)
					pair_cnt <= pair_cnt + 1'b1;
			end
			smp.valid     <= word_done;
			smp.frame_end <= word_done && (pair_cnt == PAIR_W'(N_PAIR - 1));
		end
	end

	// payload, msb first on both lines
	always_ff @(posedge clk_in) begin
		if (shift_en) begin
			sh_a <= {sh_a[SAMPLE_W-2:0], data_a};
			sh_b <= {sh_b[SAMPLE_W-2:0], data_b};
		end
		if (word_done)
			smp.pair_idx <= pair_cnt;
	end

	assign smp.value_a = sh_a;  // stable while valid, next shift is a cycle later
	assign smp.value_b = sh_b;
	assign sclk        = sclk_q;
	assign n_cs        = (rd_state != RD_SHIFT);

endmodule

`default_nettype wire

/* hw/sample_store.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_store (
	input  wire                                  clk_in,
	input  wire                                  reset_in,
	input  wire  [adc_pkg::CHAN_IDX_W-1:0]       rd_idx,
	output logic signed [adc_pkg::SAMPLE_W-1:0]  rd_value,   // combinational read
	output logic [wb_regs_pkg::FRAME_CNT_W-1:0]  frame_cnt,  // wraps
	sample_if.store                              smp
);
	import adc_pkg::*;

	logic signed [SAMPLE_W-1:0] chan_q [N_CHAN];  // latest sample per channel
	logic [CHAN_IDX_W-1:0]      idx_a;
	logic [CHAN_IDX_W-1:0]      idx_b;

	////////////////////////////////////////
	// write side
	////////////////////////////////////////

	// port a fills the low half, port b the upper half
	assign idx_a = CHAN_IDX_W'(smp.pair_idx);
	assign idx_b = CHAN_IDX_W'(smp.pair_idx) + CHAN_IDX_W'(N_PAIR);

	// newest frame overwrites, nothing to stall
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			for (int i = 0; i < N_CHAN; i++)
				chan_q[i] <= '0;  // zeros readable before the first frame
			frame_cnt <= '0;
		end else if (smp.valid) begin
			chan_q[idx_a] <= smp.value_a;
			chan_q[idx_b] <= smp.value_b;
			if (smp.frame_end)
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// read side
	////////////////////////////////////////

	assign rd_value = chan_q[rd_idx];  // decoder registers the bus word

endmodule

`default_nettype wire

/* hw/adc_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_subsys_top (
	input  wire                                clk_in,
	input  wire                                reset_in,
	// wishbone classic slave
	input  wire                                wb_cyc,
	input  wire                                wb_stb,
	input  wire                                wb_we,
	input  wire  [wb_regs_pkg::WB_ADDR_W-1:0]  wb_adr,
	input  wire  [wb_regs_pkg::WB_DATA_W-1:0]  wb_dat_w,
	input  wire  [wb_regs_pkg::WB_SEL_W-1:0]   wb_sel,
	output wire  [wb_regs_pkg::WB_DATA_W-1:0]  wb_dat_r,
	output wire                                wb_ack,
	// adc pins
	input  wire                                busy,
	input  wire                                data_a,
	input  wire                                data_b,
	output wire  [adc_pkg::OS_W-1:0]           os_pins,
	output wire                                convst,
	output wire                                sclk,
	output wire                                n_cs,
	output wire                                adc_reset
);
	import adc_pkg::*;
	import wb_regs_pkg::*;

	wire [CHAN_IDX_W-1:0]      rd_idx;     // store read port
	wire signed [SAMPLE_W-1:0] rd_value;
	wire [FRAME_CNT_W-1:0]     frame_cnt;

	conv_cfg_if cfg_bus ();  // decode to sequencer
	sample_if   smp_bus ();  // sequencer to store

	// decode
	wb_reg_decode u_decode (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_sel    (wb_sel),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.rd_idx    (rd_idx),
		.rd_value  (rd_value),
		.frame_cnt (frame_cnt),
		.cfg       (cfg_bus.dec)
	);

	// execute
	adc_seq u_seq (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.busy      (busy),
		.data_a    (data_a),
		.data_b    (data_b),
		.os_pins   (os_pins),
		.convst    (convst),
		.sclk      (sclk),
		.n_cs      (n_cs),
		.adc_reset (adc_reset),
		.cfg       (cfg_bus.seq),
		.smp       (smp_bus.seq)
	);

	// result
	sample_store u_store (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.rd_idx    (rd_idx),
		.rd_value  (rd_value),
		.frame_cnt (frame_cnt),
		.smp       (smp_bus.store)
	);

endmodule

`default_nettype wire

/* tests/adc_subsys_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// wishbone and adc pin protocol
module adc_subsys_chk (
	input wire clk_in,
	input wire reset_in,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack,
	input wire convst,
	input wire n_cs,
	input wire sclk
);

	ack_one_cycle: assert property (@(posedge clk_in) disable iff (reset_in)
		wb_ack |=> !wb_ack) else $error("ack longer than one cycle");

	// new request acked on the next clock
	ack_after_req: assert property (@(posedge clk_in) disable iff (reset_in)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack) else $error("ack late");

	convst_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
		!convst |=> convst) else $error("convst low too long");

	cs_idle_at_convst: assert property (@(posedge clk_in) disable iff (reset_in)
		!convst |-> n_cs) else $error("cs low during convst");

	sclk_parked: assert property (@(posedge clk_in) disable iff (reset_in)
		n_cs |-> !sclk) else $error("sclk high with cs high");

endmodule

bind adc_subsys_top adc_subsys_chk chk (
	.clk_in(clk_in), .reset_in(reset_in), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
	.wb_ack(wb_ack), .convst(convst), .n_cs(n_cs), .sclk(sclk)
);

`default_nettype wire

/* tests/tb_adc_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_adc_subsys;
	import adc_pkg::*;

	// op kinds
	localparam int K_FIX  = 0;  // bus op with masked compare
	localparam int K_PINS = 1;  // pin snapshot without a bus op
	localparam int K_SMP  = 2;  // sample read against the model
	localparam int K_MORE = 3;  // status read where the frame count must grow
	localparam int K_SAME = 4;  // status read with frame count and convst frozen
	localparam int MAX_OPS    = 64;
	localparam int EXP_FRAMES = 30;

	logic        clk_in = 1'b0;
	logic        reset_in;
	logic        wb_cyc, wb_stb, wb_we;
	logic [7:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [3:0]  wb_sel;
	wire  [31:0] wb_dat_r;
	wire         wb_ack;
	logic        busy, data_a, data_b;
	wire  [2:0]  os_pins;
	wire         convst, sclk, n_cs, adc_reset;

	// operation table
	int          op_kind [MAX_OPS];
	logic        op_we   [MAX_OPS];
	logic [7:0]  op_adr  [MAX_OPS];
	logic [31:0] op_wd   [MAX_OPS];
	logic [31:0] op_exp  [MAX_OPS];
	logic [31:0] op_mask [MAX_OPS];
	int          op_wait [MAX_OPS];
	int          n_ops = 0;

	int          seed = 95;
	logic [31:0] offset;        // drawn once
	int          err_mismatch = 0;
	int          err_other = 0;
	int          cycles = 0;
	int          limit = 1000000;

	// adc model state
	int   busy_dly = 0, busy_left = 0;
	int   bit_no = 0, frame_no = 0;
	int   cs_len = 0, sclk_rises = 0;
	int   conv_falls = 0, last_fall = 0;
	logic prev_convst = 1'b1, prev_ncs = 1'b1, prev_sclk = 1'b0;

	adc_subsys_top UUT (
		.clk_in(clk_in), .reset_in(reset_in),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.busy(busy), .data_a(data_a), .data_b(data_b), .os_pins(os_pins),
		.convst(convst), .sclk(sclk), .n_cs(n_cs), .adc_reset(adc_reset)
	);

	always #5 clk_in = !clk_in;

	////////////////////////////////////////
	// reference values
	////////////////////////////////////////

	function automatic logic [17:0] model_val(input int f, input int k);
		logic [31:0] t;
		t = (f * 8 + k) * 32'h1357 + offset;
		return t[17:0];
	endfunction

	function automatic logic line_bit(input int f, input int b, input int base);
		logic [17:0] v;
		if (b >= 72)
			return 1'b0;
		v = model_val(f, base + b / 18);
		return v[17 - b % 18];  // msb first
	endfunction

	////////////////////////////////////////
	// adc model and pin monitor on the falling edge
	////////////////////////////////////////

	always @(negedge clk_in) begin
		if (!reset_in) begin
			// convst fall starts a conversion
			if (!convst && prev_convst) begin
				if (conv_falls > 0 && cycles - last_fall < MIN_T_CYCLE) begin
					err_mismatch++;
					$display("MISMATCH at %0t: convst gap %0d below %0d", $time,
						cycles - last_fall, MIN_T_CYCLE);
				end
				conv_falls++;
				last_fall = cycles;
				busy_dly  = 2;
				busy_left = 40 + (8 << os_pins);
			end
			if (busy_dly > 0) begin
				busy_dly--;
				if (busy_dly == 0)
					busy = 1'b1;
			end else if (busy) begin
				busy_left--;
				if (busy_left == 0)
					busy = 1'b0;
			end
			// serial side
			if (n_cs) begin
				bit_no = 0;
			end else begin
				cs_len++;
				if (sclk && !prev_sclk)
					sclk_rises++;
				if (prev_sclk && !sclk)
					bit_no++;  // next bit after falling sclk
			end
			if (n_cs && !prev_ncs) begin
				if (cs_len != 2 * RD_LENGTH || sclk_rises != RD_LENGTH) begin
					err_mismatch++;
					$display("MISMATCH at %0t: cs low %0d cycles, %0d sclk rises", $time,
						cs_len, sclk_rises);
				end
				cs_len     = 0;
				sclk_rises = 0;
				frame_no++;
			end
			data_a = line_bit(frame_no, bit_no, 0);
			data_b = line_bit(frame_no, bit_no, 4);
		end
		prev_convst = convst;
		prev_ncs    = n_cs;
		prev_sclk   = sclk;
	end

	always @(posedge clk_in) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic add_op(input int kind, input logic we, input logic [7:0] adr,
		input logic [31:0] wd, input logic [31:0] exp, input logic [31:0] mask,
		input int wt);
		op_kind[n_ops] = kind;
		op_we[n_ops]   = we;
		op_adr[n_ops]  = adr;
		op_wd[n_ops]   = wd;
		op_exp[n_ops]  = exp;
		op_mask[n_ops] = mask;
		op_wait[n_ops] = wt;
		n_ops++;
	endtask

	task automatic add_sample_reads();
		for (int k = 0; k < 8; k++)
			add_op(K_SMP, 1'b0, 8'h20 + 8'(4 * k), 0, 0, 32'hFFFFFFFF, 0);
	endtask

	task automatic compare(input int idx, input logic [31:0] got, input logic [31:0] exp,
		input logic [31:0] mask);
		if ((got & mask) != (exp & mask)) begin
			err_mismatch++;
			$display("MISMATCH at %0t: op %0d got %h expected %h mask %h", $time, idx,
				got, exp, mask);
		end
	endtask

	// one classic cycle started on a falling edge
	task automatic bus_op(input logic we, input logic [7:0] adr, input logic [31:0] wd,
		output logic [31:0] rd);
		int n;
		n        = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wd;
		wb_sel   = 4'hF;
		do begin
			@(negedge clk_in);
			n++;
		end while (!wb_ack && n < 20);
		if (!wb_ack) begin
			err_other++;
			$display("no ack from the wishbone slave for address %h at %0t", adr, $time);
		end
		rd     = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] rd;
		logic [31:0] expw;
		logic [17:0] v;
		int          ch;
		int          last_frame;
		int          conv_mark;
		int          wait_sum;
		reset_in = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		wb_sel   = '0;
		busy     = 1'b0;
		data_a   = 1'b0;
		data_b   = 1'b0;
		offset = $random(seed);
		last_frame = 0;
		conv_mark  = 0;
		wait_sum   = 0;

		// pins {adc_reset, convst, n_cs, sclk, os} after reset
		add_op(K_PINS, 0, 0, 0, 32'b0110_001, 32'h7F, 0);
		add_op(K_FIX, 0, 8'h00, 0, 32'h2, 32'hFFFFFFFF, 0);
		add_op(K_SAME, 0, 8'h04, 0, 32'h1, 32'hFFFFFFFF, 0);
		add_sample_reads();
		// ctrl writes with clamp, unmapped and read only addresses
		add_op(K_FIX, 1, 8'h00, 32'h0, 0, 0, 0);
		add_op(K_FIX, 0, 8'h00, 0, 32'h2, 32'hFFFFFFFF, 0);
		add_op(K_FIX, 1, 8'h00, 32'hA, 0, 0, 0);
		add_op(K_FIX, 0, 8'h00, 0, 32'hA, 32'hFFFFFFFF, 2);
		add_op(K_PINS, 0, 0, 0, 32'b0110_101, 32'h7F, 0);
		add_op(K_FIX, 0, 8'h10, 0, 32'h0, 32'hFFFFFFFF, 0);
		add_op(K_FIX, 1, 8'h04, 32'hFFFFFFFF, 0, 0, 0);
		add_op(K_FIX, 0, 8'h04, 0, 32'h5, 32'hFFFFFFFF, 0);
		// first run at os 1 and stop
		add_op(K_FIX, 1, 8'h00, 32'h3, 0, 0, 1500);
		add_op(K_FIX, 1, 8'h00, 32'h2, 0, 0, 400);
		add_op(K_MORE, 0, 8'h04, 0, 32'h1, 32'hF, 0);
		add_sample_reads();
		add_op(K_PINS, 0, 0, 0, 32'b0110_001, 32'h7F, 0);
		add_op(K_SAME, 0, 8'h04, 0, 32'h1, 32'hF, 1000);
		add_op(K_SAME, 0, 8'h04, 0, 32'h1, 32'hF, 0);
		// restart at os 3
		add_op(K_FIX, 1, 8'h00, 32'h7, 0, 0, 2500);
		add_op(K_FIX, 1, 8'h00, 32'h6, 0, 0, 400);
		add_op(K_MORE, 0, 8'h04, 0, 32'h3, 32'hF, 0);
		add_sample_reads();

		for (int i = 0; i < n_ops; i++)
			wait_sum += op_wait[i];
		limit = n_ops * 2 + EXP_FRAMES * 300 + 200 + wait_sum;

		repeat (16) @(negedge clk_in);
		if (adc_reset !== 1'b1) begin
			err_mismatch++;
			$display("MISMATCH at %0t: adc_reset %b while reset is asserted", $time,
				adc_reset);
		end
		reset_in = 1'b0;
		@(negedge clk_in);

		for (int i = 0; i < n_ops; i++) begin
			if (op_kind[i] == K_PINS) begin
				compare(i, {25'd0, adc_reset, convst, n_cs, sclk, os_pins}, op_exp[i],
					op_mask[i]);
			end else begin
				bus_op(op_we[i], op_adr[i], op_wd[i], rd);
				if (!op_we[i]) begin
					case (op_kind[i])
						K_SMP: begin
							ch   = int'((op_adr[i] - 8'h20) >> 2);
							v    = (last_frame == 0) ? 18'd0 : model_val(last_frame - 1, ch);
							expw = {4'(ch), {10{v[17]}}, v};  // sign extended
							compare(i, rd, expw, op_mask[i]);
						end
						K_MORE, K_SAME: begin
							compare(i, rd, op_exp[i], op_mask[i]);
							if (op_kind[i] == K_MORE && int'(rd[31:16]) <= last_frame) begin
								err_mismatch++;
								$display("MISMATCH at %0t: frame count %0d did not grow past %0d",
									$time, rd[31:16], last_frame);
							end
							if (op_kind[i] == K_MORE && conv_falls - conv_mark < 2) begin
								err_other++;
								$display("convst did not repeat while conversion was running");
							end
							if (op_kind[i] == K_SAME && int'(rd[31:16]) != last_frame) begin
								err_mismatch++;
								$display("MISMATCH at %0t: frame count %0d, expected %0d",
									$time, rd[31:16], last_frame);
							end
							if (op_kind[i] == K_SAME && conv_falls != conv_mark) begin
								err_other++;
								$display("convst pulsed while conversion was stopped");
							end
							last_frame = int'(rd[31:16]);
							conv_mark  = conv_falls;
						end
						default: compare(i, rd, op_exp[i], op_mask[i]);
					endcase
				end
			end
			repeat (op_wait[i]) @(negedge clk_in);
		end

		$display("errors: %0d mismatches, %0d other failures", err_mismatch, err_other);
		if (err_mismatch == 0 && err_other == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
common/adc_pkg.sv
common/wb_regs_pkg.sv
common/conv_cfg_if.sv
common/sample_if.sv
hw/wb_reg_decode.sv
adc_seq/adc_seq.sv
hw/sample_store.sv
hw/adc_subsys_top.sv
tests/adc_subsys_chk.sv
tests/tb_adc_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
	--top-module tb_adc_subsys -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" sim.log; then
	exit 0
else
	exit 1
fi
